//--- all.f
+incdir+verilog
verilog/periph_pkg.sv
verilog/axi2apb_bridge.sv
verilog/apb_mux.sv
verilog/led_driver.sv
verilog/int_controller.sv
verilog/periph_top.sv
sim/periph_tb.sv

//--- run.sh
#!/bin/sh
# build and run the peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
	-f all.f --top-module periph_tb -o periph_sim

./obj_dir/periph_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

//--- sim/periph_tb.sv
`timescale 1ns/10ps

`include "periph_params.svh"

module periph_tb;

	logic clk = 1'b0;
	logic rst_n;
	logic aw_valid;
	logic aw_ready;
	periph_pkg::axi_addr_t aw;
	logic w_valid;
	logic w_ready;
	periph_pkg::axi_wdata_t w;
	logic b_valid;
	logic b_ready;
	periph_pkg::axi_bresp_t b;
	logic ar_valid;
	logic ar_ready;
	periph_pkg::axi_addr_t ar;
	logic r_valid;
	logic r_ready;
	periph_pkg::axi_rresp_t r;
	logic [`INT_NUM-1:0] int_src;
	logic [`LED_WIDTH-1:0] led;
	logic irq;

	// one table row per bus transfer
	typedef struct packed {
		logic wr;
		logic [`ADDR_WIDTH-1:0] addr;
		logic [`ID_WIDTH-1:0] id;
		logic [`DATA_WIDTH-1:0] data;
		logic [`STRB_WIDTH-1:0] strb;
		logic [`INT_NUM-1:0] src;
		logic [`DATA_WIDTH-1:0] exp_data;
		logic [1:0] exp_resp;
		logic [`LED_WIDTH-1:0] exp_led;
		logic exp_irq;
	} entry_t;

	entry_t tbl[$];
	logic [31:0] lfsr = 32'hb58a;
	int cycles = 0;
	int limit = 0;
	int errors = 0;
	int checks = 0;

	periph_top dut (
		.clk(clk), .rst_n(rst_n),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
		.w_valid(w_valid), .w_ready(w_ready), .w(w),
		.b_valid(b_valid), .b_ready(b_ready), .b(b),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
		.r_valid(r_valid), .r_ready(r_ready), .r(r),
		.int_src(int_src), .led(led), .irq(irq)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// run limit, scaled to the table
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: no response after %0d clock cycles, run stopped", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic add_entry(input logic wr, input logic [31:0] addr, input logic [3:0] id,
			input logic [31:0] data, input logic [3:0] strb, input logic [7:0] src,
			input logic [31:0] exp_data, input logic [1:0] exp_resp,
			input logic [1:0] exp_led, input logic exp_irq);
		entry_t e;
		e.wr = wr;
		e.addr = addr;
		e.id = id;
		e.data = data;
		e.strb = strb;
		e.src = src;
		e.exp_data = exp_data;
		e.exp_resp = exp_resp;
		e.exp_led = exp_led;
		e.exp_irq = exp_irq;
		tbl.push_back(e);
	endtask

	task automatic check_bresp(input periph_pkg::axi_bresp_t got,
			input periph_pkg::axi_bresp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t b got id %0d resp %0d, expected id %0d resp %0d",
				$time, got.id, got.resp, exp.id, exp.resp);
		end
	endtask

	task automatic check_rresp(input periph_pkg::axi_rresp_t got,
			input periph_pkg::axi_rresp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t r got id %0d data %h resp %0d, expected id %0d data %h resp %0d",
				$time, got.id, got.data, got.resp, exp.id, exp.data, exp.resp);
		end
	endtask

	task automatic check_led(input logic [`LED_WIDTH-1:0] got,
			input logic [`LED_WIDTH-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t led got %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t irq got %b, expected %b", $time, got, exp);
		end
	endtask

	// response pending: no new request taken, valid held
	task automatic check_stall(input logic is_wr);
		checks++;
		if (aw_ready || w_ready || ar_ready || !(is_wr ? b_valid : r_valid)) begin
			errors++;
			$display("ERR %0t stall broken, aw_ready %b w_ready %b ar_ready %b valid %b",
				$time, aw_ready, w_ready, ar_ready, is_wr ? b_valid : r_valid);
		end
	endtask

	// wait for valid, then 0..3 cycles of back-pressure
	task automatic hold_resp(input logic is_wr);
		int n;
		@(negedge clk);
		while (!(is_wr ? b_valid : r_valid))
			@(negedge clk);
		lfsr = lfsr_step(lfsr);
		n = lfsr[0];
		lfsr = lfsr_step(lfsr);
		n = n * 2 + lfsr[0];
		repeat (n) begin
			check_stall(is_wr);
			@(negedge clk);
		end
		check_stall(is_wr);
		@(posedge clk);
		#1;
		if (is_wr)
			b_ready = 1'b1;
		else
			r_ready = 1'b1;
		// sample mid-cycle, handshake on the next edge
		@(negedge clk);
	endtask

	task automatic do_write(input entry_t e);
		periph_pkg::axi_bresp_t exp_b;
		logic aw_done;
		logic w_done;
		logic aw_hs;
		logic w_hs;
		exp_b.id = e.id;
		exp_b.resp = e.exp_resp;
		aw_done = 1'b0;
		w_done = 1'b0;
		// both channels launched together
		aw.id = e.id;
		aw.addr = e.addr;
		aw_valid = 1'b1;
		w.data = e.data;
		w.strb = e.strb;
		w_valid = 1'b1;
		while (!(aw_done && w_done)) begin
			@(negedge clk);
			aw_hs = aw_valid && aw_ready;
			w_hs = w_valid && w_ready;
			@(posedge clk);
			#1;
			if (aw_hs) begin
				aw_valid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_hs) begin
				w_valid = 1'b0;
				w_done = 1'b1;
			end
		end
		hold_resp(1'b1);
		check_bresp(b, exp_b);
		@(posedge clk);
		#1;
		b_ready = 1'b0;
	endtask

	task automatic do_read(input entry_t e);
		periph_pkg::axi_rresp_t exp_r;
		logic ar_hs;
		exp_r.id = e.id;
		exp_r.data = e.exp_data;
		exp_r.resp = e.exp_resp;
		ar_hs = 1'b0;
		ar.id = e.id;
		ar.addr = e.addr;
		ar_valid = 1'b1;
		while (!ar_hs) begin
			@(negedge clk);
			ar_hs = ar_valid && ar_ready;
			@(posedge clk);
			#1;
		end
		ar_valid = 1'b0;
		hold_resp(1'b0);
		check_rresp(r, exp_r);
		@(posedge clk);
		#1;
		r_ready = 1'b0;
	endtask

	task automatic run_entry(input entry_t e);
		// new source levels, edge seen on the next clock
		@(posedge clk);
		#1;
		int_src = e.src;
		if (e.wr)
			do_write(e);
		else
			do_read(e);
		@(negedge clk);
		check_led(led, e.exp_led);
		check_irq(irq, e.exp_irq);
	endtask

	initial begin
		int err_before;
		rst_n = 1'b0;
		aw_valid = 1'b0;
		aw = '0;
		w_valid = 1'b0;
		w = '0;
		b_ready = 1'b0;
		ar_valid = 1'b0;
		ar = '0;
		r_ready = 1'b0;
		int_src = '0;

		// wr addr id data strb src exp_data exp_resp exp_led exp_irq
		// led register, strobe 0 write leaves it alone
		add_entry(1'b1, 32'h0000_0000, 4'd1, 32'h3, 4'h1, 8'h00, 32'h0, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_0000, 4'd2, 32'h0, 4'h0, 8'h00, 32'h3, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b1, 32'h0000_0000, 4'd3, 32'h0, 4'h0, 8'h00, 32'h0, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_0000, 4'd4, 32'h0, 4'h0, 8'h00, 32'h3, `RESP_OKAY, 2'd3, 1'b0);
		// unmapped select 2
		add_entry(1'b1, 32'h0000_2000, 4'd5, 32'h55, 4'hf, 8'h00, 32'h0, `RESP_SLVERR, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_2004, 4'd6, 32'h0, 4'h0, 8'h00, 32'h0, `RESP_SLVERR, 2'd3, 1'b0);
		// sources 1 and 5 rise, mask still closed
		add_entry(1'b0, 32'h0000_1008, 4'd7, 32'h0, 4'h0, 8'h22, 32'h22, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_1000, 4'd8, 32'h0, 4'h0, 8'h22, 32'h22, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_1004, 4'd9, 32'h0, 4'h0, 8'h22, 32'h0, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b1, 32'h0000_1004, 4'd10, 32'h20, 4'h1, 8'h22, 32'h0, `RESP_OKAY, 2'd3, 1'b1);
		add_entry(1'b0, 32'h0000_1004, 4'd11, 32'h0, 4'h0, 8'h22, 32'h20, `RESP_OKAY, 2'd3, 1'b1);
		// write 1 to clear bit 5, held source does not re-set it
		add_entry(1'b1, 32'h0000_1008, 4'd12, 32'h20, 4'h1, 8'h22, 32'h0, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_1008, 4'd13, 32'h0, 4'h0, 8'h22, 32'h02, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_1000, 4'd14, 32'h0, 4'h0, 8'h22, 32'h22, `RESP_OKAY, 2'd3, 1'b0);
		// hole in the map
		add_entry(1'b1, 32'h0000_100c, 4'd15, 32'hff, 4'hf, 8'h22, 32'h0, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_100c, 4'd0, 32'h0, 4'h0, 8'h22, 32'h0, `RESP_OKAY, 2'd3, 1'b0);
		// bit 5 low then high again, a fresh edge
		add_entry(1'b0, 32'h0000_1008, 4'd1, 32'h0, 4'h0, 8'h02, 32'h02, `RESP_OKAY, 2'd3, 1'b0);
		add_entry(1'b0, 32'h0000_1008, 4'd2, 32'h0, 4'h0, 8'h22, 32'h22, `RESP_OKAY, 2'd3, 1'b1);
		add_entry(1'b1, 32'h0000_0000, 4'd3, 32'hffff_fffe, 4'h1, 8'h22, 32'h0, `RESP_OKAY,
			2'd2, 1'b1);
		add_entry(1'b0, 32'h0000_0000, 4'd4, 32'h0, 4'h0, 8'h22, 32'h2, `RESP_OKAY, 2'd2, 1'b1);
		add_entry(1'b1, 32'h0000_1008, 4'd5, 32'h22, 4'h1, 8'h22, 32'h0, `RESP_OKAY, 2'd2, 1'b0);
		add_entry(1'b0, 32'h0000_1008, 4'd6, 32'h0, 4'h0, 8'h22, 32'h0, `RESP_OKAY, 2'd2, 1'b0);
		// far select value
		add_entry(1'b0, 32'h0001_0000, 4'd9, 32'h0, 4'h0, 8'h22, 32'h0, `RESP_SLVERR, 2'd2, 1'b0);
		limit = tbl.size() * 20 + 100;

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		foreach (tbl[i]) begin
			err_before = errors;
			run_entry(tbl[i]);
			$display("test %0d %s addr %h id %0d: %s", i, tbl[i].wr ? "write" : "read",
				tbl[i].addr, tbl[i].id, (errors == err_before) ? "ok" : "mismatch");
		end

		$display("%0d tests, %0d checks, %0d errors", tbl.size(), checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- verilog/periph_top.sv
`timescale 1ns/10ps

`include "periph_params.svh"

module periph_top (
	input logic clk,
	input logic rst_n,
	input logic aw_valid,
	output logic aw_ready,
	input periph_pkg::axi_addr_t aw,
	input logic w_valid,
	output logic w_ready,
	input periph_pkg::axi_wdata_t w,
	output logic b_valid,
	input logic b_ready,
	output periph_pkg::axi_bresp_t b,
	input logic ar_valid,
	output logic ar_ready,
	input periph_pkg::axi_addr_t ar,
	output logic r_valid,
	input logic r_ready,
	output periph_pkg::axi_rresp_t r,
	input logic [`INT_NUM-1:0] int_src,
	output logic [`LED_WIDTH-1:0] led,
	output logic irq
);

	// bridge to decoder
	periph_pkg::apb_req_t cpu_req;
	periph_pkg::apb_rsp_t cpu_rsp;
	// decoder to slaves
	periph_pkg::apb_req_t led_req;
	periph_pkg::apb_rsp_t led_rsp;
	periph_pkg::apb_req_t int_req;
	periph_pkg::apb_rsp_t int_rsp;

	axi2apb_bridge u_bridge (
		.clk(clk), .rst_n(rst_n),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
		.w_valid(w_valid), .w_ready(w_ready), .w(w),
		.b_valid(b_valid), .b_ready(b_ready), .b(b),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
		.r_valid(r_valid), .r_ready(r_ready), .r(r),
		.apb_req(cpu_req), .apb_rsp(cpu_rsp)
	);

	apb_mux u_mux (
		.cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
		.led_req(led_req), .led_rsp(led_rsp),
		.int_req(int_req), .int_rsp(int_rsp)
	);

	// slave 0
	led_driver u_led (
		.clk(clk), .rst_n(rst_n),
		.apb_req(led_req), .apb_rsp(led_rsp),
		.led(led)
	);

	// slave 1
	int_controller u_int (
		.clk(clk), .rst_n(rst_n),
		.apb_req(int_req), .apb_rsp(int_rsp),
		.int_src(int_src), .irq(irq)
	);

endmodule

//--- verilog/int_controller.sv
`timescale 1ns/10ps

`include "periph_params.svh"

module int_controller (
	input logic clk,
	input logic rst_n,
	input periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,
	input logic [`INT_NUM-1:0] int_src,
	output logic irq
);

	logic [`INT_NUM-1:0] src_q;
	logic [`INT_NUM-1:0] rise;
	logic [`INT_NUM-1:0] enable;
	logic [`INT_NUM-1:0] pending;
	logic [`INT_NUM-1:0] clr;
	logic [`SLV_SEL_LSB-1:0] offset;
	logic access;
	logic wr_en;
	logic [`INT_NUM-1:0] rd_val;

	// register offset inside the page
	assign offset = apb_req.addr[`SLV_SEL_LSB-1:0];
	assign access = apb_req.sel && apb_req.enable;
	// all interrupt bits sit in byte lane 0
	assign wr_en = access && apb_req.write && apb_req.strb[0];

	// rising edge against last cycle's sample
	assign rise = int_src & ~src_q;

	// write 1 to clear
	assign clr = (wr_en && offset == `REG_PENDING) ? apb_req.wdata[`INT_NUM-1:0] : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			src_q <= '0;
			enable <= '0;
			pending <= '0;
		end else begin
			src_q <= int_src;
			if (wr_en && offset == `REG_ENABLE)
				enable <= apb_req.wdata[`INT_NUM-1:0];
			// a new edge beats a clear in the same cycle
			pending <= (pending & ~clr) | rise;
		end
	end

	// read mux
	always_comb begin
		case (offset)
			`REG_STATUS: rd_val = int_src;
			`REG_ENABLE: rd_val = enable;
			`REG_PENDING: rd_val = pending;
			// holes read zero
			default: rd_val = '0;
		endcase
	end

	assign apb_rsp.rdata = {{(`DATA_WIDTH-`INT_NUM){1'b0}}, rd_val};
	assign apb_rsp.ack = access;
	assign apb_rsp.err = 1'b0;

	// one cpu interrupt
	assign irq = |(pending & enable);

endmodule

//--- verilog/led_driver.sv
`timescale 1ns/10ps

`include "periph_params.svh"

module led_driver (
	input logic clk,
	input logic rst_n,
	input periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,
	output logic [`LED_WIDTH-1:0] led
);

	logic [`LED_WIDTH-1:0] led_q;
	logic access;
	logic wr_en;

	// single register, the address offset is not decoded
	assign access = apb_req.sel && apb_req.enable;
	// only byte lane 0 carries led bits
	assign wr_en = access && apb_req.write && apb_req.strb[0];

	always_ff @(posedge clk) begin
		if (!rst_n)
			led_q <= '0;
		else if (wr_en)
			led_q <= apb_req.wdata[`LED_WIDTH-1:0];
	end

	assign led = led_q;

	// zero wait state, never errors
	assign apb_rsp.ack = access;
	assign apb_rsp.err = 1'b0;
	// read back, zero-extended
	assign apb_rsp.rdata = {{(`DATA_WIDTH-`LED_WIDTH){1'b0}}, led_q};

endmodule

//--- verilog/apb_mux.sv
`timescale 1ns/10ps

`include "periph_params.svh"

module apb_mux (
	input periph_pkg::apb_req_t cpu_req,
	output periph_pkg::apb_rsp_t cpu_rsp,
	output periph_pkg::apb_req_t led_req,
	input periph_pkg::apb_rsp_t led_rsp,
	output periph_pkg::apb_req_t int_req,
	input periph_pkg::apb_rsp_t int_rsp
);

	logic [`ADDR_WIDTH-`SLV_SEL_LSB-1:0] slv_sel;
	logic hit_led;
	logic hit_int;

	// everything above the 4K page picks the slave
	assign slv_sel = cpu_req.addr[`ADDR_WIDTH-1:`SLV_SEL_LSB];
	assign hit_led = (slv_sel == `SLV_LED);
	assign hit_int = (slv_sel == `SLV_INT);

	// request fan-out
	always_comb begin
		led_req = cpu_req;
		int_req = cpu_req;
		// only the addressed slave sees its select
		led_req.sel = cpu_req.sel && hit_led;
		int_req.sel = cpu_req.sel && hit_int;
	end

	// response steering
	always_comb begin
		if (hit_led) begin
			cpu_rsp = led_rsp;
		end else if (hit_int) begin
			cpu_rsp = int_rsp;
		end else begin
			// unmapped, answer here in the first access cycle
			cpu_rsp.rdata = '0;
			cpu_rsp.ack = cpu_req.sel && cpu_req.enable;
			cpu_rsp.err = 1'b1;
		end
	end

	// decode must be one-hot at most
	always_comb begin
		a_one_sel: assert final (!(led_req.sel && int_req.sel));
	end

endmodule

//--- verilog/axi2apb_bridge.sv
`timescale 1ns/10ps

`include "periph_params.svh"

module axi2apb_bridge (
	input logic clk,
	input logic rst_n,
	input logic aw_valid,
	output logic aw_ready,
	input periph_pkg::axi_addr_t aw,
	input logic w_valid,
	output logic w_ready,
	input periph_pkg::axi_wdata_t w,
	output logic b_valid,
	input logic b_ready,
	output periph_pkg::axi_bresp_t b,
	input logic ar_valid,
	output logic ar_ready,
	input periph_pkg::axi_addr_t ar,
	output logic r_valid,
	input logic r_ready,
	output periph_pkg::axi_rresp_t r,
	output periph_pkg::apb_req_t apb_req,
	input periph_pkg::apb_rsp_t apb_rsp
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS,
		ST_RESP
	} state_t;

	state_t state;
	state_t state_d;
	logic aw_got;
	logic w_got;
	logic ar_got;
	logic aw_got_d;
	logic w_got_d;
	logic ar_got_d;
	logic is_write;
	logic start_wr;
	logic start_rd;
	periph_pkg::axi_addr_t aw_q;
	periph_pkg::axi_addr_t ar_q;
	periph_pkg::axi_wdata_t w_q;
	logic [`DATA_WIDTH-1:0] rdata_q;
	logic err_q;

	// write wins when both sides are ready in the same cycle
	assign start_wr = (state == ST_IDLE) && aw_got && w_got;
	assign start_rd = (state == ST_IDLE) && !start_wr && ar_got;

	always_comb begin
		state_d = state;
		// one capture flag per channel
		aw_got_d = aw_got | (aw_valid & aw_ready);
		w_got_d = w_got | (w_valid & w_ready);
		ar_got_d = ar_got | (ar_valid & ar_ready);
		case (state)
			ST_IDLE: begin
				if (start_wr) begin
					state_d = ST_SETUP;
					aw_got_d = 1'b0;
					w_got_d = 1'b0;
				end else if (start_rd) begin
					state_d = ST_SETUP;
					ar_got_d = 1'b0;
				end
			end
			ST_SETUP: state_d = ST_ACCESS;
			// slow slaves just stretch this state
			ST_ACCESS: if (apb_rsp.ack) state_d = ST_RESP;
			// hold the response until the master takes it
			ST_RESP: if (is_write ? b_ready : r_ready) state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			ar_got <= 1'b0;
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
			ar_ready <= 1'b0;
			is_write <= 1'b0;
		end else begin
			state <= state_d;
			aw_got <= aw_got_d;
			w_got <= w_got_d;
			ar_got <= ar_got_d;
			// readies only while idle and the channel is still empty
			aw_ready <= (state_d == ST_IDLE) && !aw_got_d;
			w_ready <= (state_d == ST_IDLE) && !w_got_d;
			ar_ready <= (state_d == ST_IDLE) && !ar_got_d;
			if (start_wr)
				is_write <= 1'b1;
			else if (start_rd)
				is_write <= 1'b0;
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if (aw_valid && aw_ready)
			aw_q <= aw;
		if (w_valid && w_ready)
			w_q <= w;
		if (ar_valid && ar_ready)
			ar_q <= ar;
		// sample slave data on the ack edge
		if (state == ST_ACCESS && apb_rsp.ack) begin
			rdata_q <= apb_rsp.rdata;
			err_q <= apb_rsp.err;
		end
	end

	// apb side
	assign apb_req.sel = (state == ST_SETUP) || (state == ST_ACCESS);
	assign apb_req.enable = (state == ST_ACCESS);
	assign apb_req.write = is_write;
	assign apb_req.addr = is_write ? aw_q.addr : ar_q.addr;
	assign apb_req.wdata = w_q.data;
	assign apb_req.strb = is_write ? w_q.strb : '0;

	// axi responses
	assign b_valid = (state == ST_RESP) && is_write;
	assign r_valid = (state == ST_RESP) && !is_write;
	assign b.id = aw_q.id;
	assign b.resp = err_q ? `RESP_SLVERR : `RESP_OKAY;
	assign r.id = ar_q.id;
	assign r.data = rdata_q;
	assign r.resp = err_q ? `RESP_SLVERR : `RESP_OKAY;

	// access phase always comes out of a setup phase
	a_enable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.enable |-> apb_req.sel && $past(apb_req.sel));

	// one transfer in flight means never both responses at once
	a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
		!(b_valid && r_valid));

endmodule

//--- verilog/periph_pkg.sv
`include "periph_params.svh"

package periph_pkg;

	// aw / ar request beat
	typedef struct packed {
		logic [`ID_WIDTH-1:0] id;
		logic [`ADDR_WIDTH-1:0] addr;
	} axi_addr_t;

	// w beat, single beat so no last
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] data;
		logic [`STRB_WIDTH-1:0] strb;
	} axi_wdata_t;

	// b beat
	typedef struct packed {
		logic [`ID_WIDTH-1:0] id;
		logic [1:0] resp;
	} axi_bresp_t;

	// r beat
	typedef struct packed {
		logic [`ID_WIDTH-1:0] id;
		logic [`DATA_WIDTH-1:0] data;
		logic [1:0] resp;
	} axi_rresp_t;

	// apb request, master to slave
	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		logic [`ADDR_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] wdata;
		logic [`STRB_WIDTH-1:0] strb;
	} apb_req_t;

	// apb response, slave to master
	// ack ends the access phase
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] rdata;
		logic ack;
		logic err;
	} apb_rsp_t;

endpackage

//--- verilog/periph_params.svh
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define STRB_WIDTH 4
`define ID_WIDTH 4

// peripheral sizes
`define LED_WIDTH 2
`define INT_NUM 8

// slave select field, addr[31:12]
`define SLV_SEL_LSB 12
`define SLV_LED 0
`define SLV_INT 1

// interrupt controller register offsets, within the 4K page
`define REG_STATUS 12'h000
`define REG_ENABLE 12'h004
`define REG_PENDING 12'h008

// axi response codes
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`endif
